// File: src/vlane_macros.svh
// vector lane sizing
`ifndef VLANE_MACROS_SVH
`define VLANE_MACROS_SVH

// register file shape
`define VLANE_NREGS 4
`define VLANE_REG_W 2

// elements per register
`define VLANE_MAXVL 8
`define VLANE_IDX_W 3

// vl runs 0..MAXVL, so one bit wider than an index
`define VLANE_VL_W 4

`endif

// File: src/vlane_pkg.sv
// vector lane types
package vlane_pkg;

  // element-wise operations, already decoded
  typedef enum logic [3:0] {
    VALU_ADD,
    VALU_SUB,
    VALU_AND,
    VALU_OR,
    VALU_XOR,
    VALU_SLL,
    VALU_SRL,
    VALU_SRA,
    VALU_MIN,
    VALU_MINU,
    VALU_MAX,
    VALU_MAXU,
    VALU_SEQ,
    VALU_SLT,
    VALU_SLTU,
    VALU_EXT
  } valu_op_t;

  // selected element width
  typedef enum logic [1:0] {
    SEW8,
    SEW16,
    SEW32
  } sew_t;

  // extension from the lower half of SEW
  typedef enum logic {
    F2Z,
    F2S
  } ext_type_t;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    FINISH
  } seq_state_t;

  // one element word seen as a word, two halves or four bytes
  typedef union packed {
    logic [31:0]       w;
    logic [1:0][15:0]  h;
    logic [3:0][7:0]   b;
  } elem_word_u;

endpackage

// File: src/vlane_if.sv
// lane element datapath interface
`timescale 1ns/10ps
`include "vlane_macros.svh"

interface vlane_if import vlane_pkg::*; ();

  // operation fields for the current element
  valu_op_t                  aluop;
  sew_t                      sew;
  ext_type_t                 ext_type;
  logic                      reduction_ena;
  logic [`VLANE_IDX_W-1:0]   index;
  logic                      first;

  // operand selection and data
  logic [`VLANE_REG_W-1:0]   vs1_sel;
  logic [`VLANE_REG_W-1:0]   vs2_sel;
  logic [31:0]               vs1_data;
  logic [31:0]               vs2_data;
  logic [31:0]               wdata;

  modport seq (
    output aluop, sew, ext_type, reduction_ena, index, first, vs1_sel, vs2_sel
  );

  modport rf (
    input  vs1_sel, vs2_sel, index,
    output vs1_data, vs2_data
  );

  modport alu (
    input  aluop, sew, ext_type, reduction_ena, index, first, vs1_data, vs2_data,
    output wdata
  );

endinterface

// File: src/elem_counter.sv
// element index counter
`timescale 1ns/10ps
`include "vlane_macros.svh"

module elem_counter (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    clear,
  input  logic                    step,
  input  logic [`VLANE_VL_W-1:0]  vl,
  output logic [`VLANE_IDX_W-1:0] index,
  output logic                    last
);

  logic [`VLANE_VL_W-1:0] index_ext;
  logic [`VLANE_VL_W-1:0] last_index;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      index <= '0;
    end else if (clear) begin
      index <= '0;
    end else if (step) begin
      // wraps to zero after the final element of a full register
      index <= index + 1'b1;
    end
  end

  // compare at vl width so vl of 0 never matches
  assign index_ext  = {1'b0, index};
  assign last_index = vl - 1'b1;
  assign last       = (index_ext == last_index);

endmodule

// File: src/lane_sequencer.sv
// lane operation sequencer
`timescale 1ns/10ps
`include "vlane_macros.svh"

module lane_sequencer import vlane_pkg::*; (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    start,
  input  valu_op_t                aluop,
  input  sew_t                    sew,
  input  ext_type_t               ext_type,
  input  logic                    reduction,
  input  logic [`VLANE_REG_W-1:0] vs1,
  input  logic [`VLANE_REG_W-1:0] vs2,
  input  logic [`VLANE_REG_W-1:0] vd,
  input  logic [`VLANE_VL_W-1:0]  vl,
  vlane_if.seq                    vif,
  input  logic [`VLANE_IDX_W-1:0] index,
  input  logic                    last,
  output logic                    clear,
  output logic                    step,
  output logic [`VLANE_VL_W-1:0]  run_vl,
  output logic                    wr_en,
  output logic [`VLANE_REG_W-1:0] wr_vreg,
  output logic [`VLANE_IDX_W-1:0] wr_index,
  output logic                    busy,
  output logic                    done
);

  seq_state_t              state;
  seq_state_t              next_state;
  valu_op_t                aluop_q;
  sew_t                    sew_q;
  ext_type_t               ext_type_q;
  logic                    reduction_q;
  logic [`VLANE_REG_W-1:0] vs1_q;
  logic [`VLANE_REG_W-1:0] vs2_q;
  logic [`VLANE_REG_W-1:0] vd_q;
  logic                    running;

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        // zero length skips straight to the done pulse
        if (start) begin
          next_state = (vl != '0) ? RUN : FINISH;
        end
      end
      RUN: begin
        if (last) begin
          next_state = FINISH;
        end
      end
      FINISH:  next_state = IDLE;
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state       <= IDLE;
      aluop_q     <= VALU_ADD;
      sew_q       <= SEW8;
      ext_type_q  <= F2Z;
      reduction_q <= 1'b0;
      vs1_q       <= '0;
      vs2_q       <= '0;
      vd_q        <= '0;
      run_vl      <= '0;
    end else begin
      state <= next_state;
      // capture the operation once per start
      if ((state == IDLE) && start) begin
        aluop_q     <= aluop;
        sew_q       <= sew;
        ext_type_q  <= ext_type;
        reduction_q <= reduction;
        vs1_q       <= vs1;
        vs2_q       <= vs2;
        vd_q        <= vd;
        run_vl      <= vl;
      end
    end
  end

  assign running = (state == RUN);

  // counter held at zero outside RUN
  assign clear = !running;
  assign step  = running;

  assign vif.aluop         = aluop_q;
  assign vif.sew           = sew_q;
  assign vif.ext_type      = ext_type_q;
  assign vif.reduction_ena = reduction_q && running;
  assign vif.index         = index;
  assign vif.first         = (index == '0);
  assign vif.vs1_sel       = vs1_q;
  assign vif.vs2_sel       = vs2_q;

  // reductions write the fold into element 0 on the last step
  assign wr_en    = running && (!reduction_q || last);
  assign wr_vreg  = vd_q;
  assign wr_index = reduction_q ? '0 : index;

  assign busy = running;
  assign done = (state == FINISH);

endmodule

// File: src/vreg_file.sv
// vector register file
`timescale 1ns/10ps
`include "vlane_macros.svh"

module vreg_file import vlane_pkg::*; (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    load_en,
  input  logic [`VLANE_REG_W-1:0] load_vreg,
  input  logic [`VLANE_IDX_W-1:0] load_index,
  input  logic [31:0]             load_data,
  input  logic                    busy,
  input  logic                    wr_en,
  input  logic [`VLANE_REG_W-1:0] wr_vreg,
  input  logic [`VLANE_IDX_W-1:0] wr_index,
  input  logic [31:0]             wdata,
  vlane_if.rf                     vif,
  input  logic [`VLANE_REG_W-1:0] rd_vreg,
  input  logic [`VLANE_IDX_W-1:0] rd_index,
  output logic [31:0]             rd_data
);

  elem_word_u regs [`VLANE_NREGS][`VLANE_MAXVL];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int r = 0; r < `VLANE_NREGS; r++) begin
        for (int e = 0; e < `VLANE_MAXVL; e++) begin
          regs[r][e] <= '0;
        end
      end
    end else if (wr_en) begin
      regs[wr_vreg][wr_index].w <= wdata;
    end else if (load_en && !busy) begin
      // external loads only land while the lane is idle
      regs[load_vreg][load_index].w <= load_data;
    end
  end

  // both lane operands come from the same element slot
  assign vif.vs1_data = regs[vif.vs1_sel][vif.index].w;
  assign vif.vs2_data = regs[vif.vs2_sel][vif.index].w;

  assign rd_data = regs[rd_vreg][rd_index].w;

endmodule

// File: src/arithmetic_unit.sv
// lane arithmetic unit
`timescale 1ns/10ps

module arithmetic_unit import vlane_pkg::*; (
  input logic  CLK,
  input logic  nRST,
  vlane_if.alu vif
);

  logic [31:0] accumulator;
  elem_word_u  opa;
  elem_word_u  opb;
  logic [31:0] sext_a;
  logic [31:0] sext_b;
  logic [4:0]  shamt;
  logic        slt;
  logic        sltu;
  logic        seq;
  logic [31:0] ext;
  logic [31:0] result;

  // low SEW bits sign-extended to a full word
  function automatic logic [31:0] sew_sext(elem_word_u v, sew_t s);
    case (s)
      SEW8:    return {{24{v.b[0][7]}}, v.b[0]};
      SEW16:   return {{16{v.h[0][15]}}, v.h[0]};
      default: return v.w;
    endcase
  endfunction

  // reductions fold into the accumulator after the seed element
  assign opa = (vif.reduction_ena && !vif.first) ? accumulator : vif.vs1_data;
  assign opb = vif.vs2_data;

  assign sext_a = sew_sext(opa, vif.sew);
  assign sext_b = sew_sext(opb, vif.sew);

  // comparisons are vs2 against vs1
  assign slt  = $signed(sext_b) < $signed(sext_a);
  assign sltu = opb.w < opa.w;
  assign seq  = opb.w == opa.w;

  // shift amount covers exactly one SEW
  always_comb begin
    case (vif.sew)
      SEW8:    shamt = {2'b00, opa.b[0][2:0]};
      SEW16:   shamt = {1'b0, opa.b[0][3:0]};
      default: shamt = opa.b[0][4:0];
    endcase
  end

  // source field is the lower half of SEW
  always_comb begin
    case (vif.sew)
      SEW8: begin
        if (vif.ext_type == F2S) begin
          ext = {{28{opb.b[0][3]}}, opb.b[0][3:0]};
        end else begin
          ext = {28'd0, opb.b[0][3:0]};
        end
      end
      SEW16: begin
        if (vif.ext_type == F2S) begin
          ext = {{24{opb.b[0][7]}}, opb.b[0]};
        end else begin
          ext = {24'd0, opb.b[0]};
        end
      end
      default: begin
        if (vif.ext_type == F2S) begin
          ext = {{16{opb.h[0][15]}}, opb.h[0]};
        end else begin
          ext = {16'd0, opb.h[0]};
        end
      end
    endcase
  end

  always_comb begin
    case (vif.aluop)
      VALU_ADD:  result = opb.w + opa.w;
      VALU_SUB:  result = opb.w - opa.w;
      VALU_AND:  result = opb.w & opa.w;
      VALU_OR:   result = opb.w | opa.w;
      VALU_XOR:  result = opb.w ^ opa.w;
      VALU_SLL:  result = opb.w << shamt;
      VALU_SRL:  result = opb.w >> shamt;
      // arithmetic shift of the whole word
      VALU_SRA:  result = $unsigned($signed(opb.w) >>> shamt);
      VALU_MIN:  result = slt ? opb.w : opa.w;
      VALU_MINU: result = sltu ? opb.w : opa.w;
      VALU_MAX:  result = slt ? opa.w : opb.w;
      VALU_MAXU: result = sltu ? opa.w : opb.w;
      VALU_SEQ:  result = {31'd0, seq};
      VALU_SLT:  result = {31'd0, slt};
      VALU_SLTU: result = {31'd0, sltu};
      VALU_EXT:  result = ext;
      default:   result = '0;
    endcase
  end

  // in a reduction wdata is the running fold
  assign vif.wdata = result;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      accumulator <= '0;
    end else if (vif.reduction_ena) begin
      accumulator <= result;
    end
  end

endmodule

// File: src/vector_lane_top.sv
// vector lane top level
`timescale 1ns/10ps
`include "vlane_macros.svh"

module vector_lane_top import vlane_pkg::*; (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    start,
  input  valu_op_t                aluop,
  input  sew_t                    sew,
  input  ext_type_t               ext_type,
  input  logic                    reduction,
  input  logic [`VLANE_REG_W-1:0] vs1,
  input  logic [`VLANE_REG_W-1:0] vs2,
  input  logic [`VLANE_REG_W-1:0] vd,
  input  logic [`VLANE_VL_W-1:0]  vl,
  input  logic                    load_en,
  input  logic [`VLANE_REG_W-1:0] load_vreg,
  input  logic [`VLANE_IDX_W-1:0] load_index,
  input  logic [31:0]             load_data,
  input  logic [`VLANE_REG_W-1:0] rd_vreg,
  input  logic [`VLANE_IDX_W-1:0] rd_index,
  output logic                    busy,
  output logic                    done,
  output logic [31:0]             rd_data
);

  logic                    cnt_clear;
  logic                    cnt_step;
  logic [`VLANE_VL_W-1:0]  cnt_vl;
  logic [`VLANE_IDX_W-1:0] cnt_index;
  logic                    cnt_last;
  logic                    wr_en;
  logic [`VLANE_REG_W-1:0] wr_vreg;
  logic [`VLANE_IDX_W-1:0] wr_index;

  vlane_if vif_i ();

  elem_counter counter_i (
    .CLK   (CLK),
    .nRST  (nRST),
    .clear (cnt_clear),
    .step  (cnt_step),
    .vl    (cnt_vl),
    .index (cnt_index),
    .last  (cnt_last)
  );

  lane_sequencer sequencer_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .start     (start),
    .aluop     (aluop),
    .sew       (sew),
    .ext_type  (ext_type),
    .reduction (reduction),
    .vs1       (vs1),
    .vs2       (vs2),
    .vd        (vd),
    .vl        (vl),
    .vif       (vif_i.seq),
    .index     (cnt_index),
    .last      (cnt_last),
    .clear     (cnt_clear),
    .step      (cnt_step),
    .run_vl    (cnt_vl),
    .wr_en     (wr_en),
    .wr_vreg   (wr_vreg),
    .wr_index  (wr_index),
    .busy      (busy),
    .done      (done)
  );

  vreg_file regfile_i (
    .CLK        (CLK),
    .nRST       (nRST),
    .load_en    (load_en),
    .load_vreg  (load_vreg),
    .load_index (load_index),
    .load_data  (load_data),
    .busy       (busy),
    .wr_en      (wr_en),
    .wr_vreg    (wr_vreg),
    .wr_index   (wr_index),
    .wdata      (vif_i.wdata),
    .vif        (vif_i.rf),
    .rd_vreg    (rd_vreg),
    .rd_index   (rd_index),
    .rd_data    (rd_data)
  );

  arithmetic_unit alu_i (
    .CLK  (CLK),
    .nRST (nRST),
    .vif  (vif_i.alu)
  );

endmodule

// File: tests/vector_lane_tb.sv
// vector lane testbench
`timescale 1ns/10ps
`include "vlane_macros.svh"

module vector_lane_tb import vlane_pkg::*; ();

  localparam int RESET_CYCLES = 5;
  // loads, element ops, sew ops, reductions, timing runs
  localparam int NUM_OPS      = 1 + (3 * 17 + 1) + 3 * 8 + 8 + 3;
  localparam int NUM_LOADS    = 32 + 3 * 16 + 3 * 16 + 16;
  localparam int CYCLE_LIMIT  = NUM_OPS * 40 + RESET_CYCLES + 2 * NUM_LOADS;

  logic                    CLK;
  logic                    nRST;
  logic                    start;
  valu_op_t                aluop;
  sew_t                    sew;
  ext_type_t               ext_type;
  logic                    reduction;
  logic [`VLANE_REG_W-1:0] vs1;
  logic [`VLANE_REG_W-1:0] vs2;
  logic [`VLANE_REG_W-1:0] vd;
  logic [`VLANE_VL_W-1:0]  vl;
  logic                    load_en;
  logic [`VLANE_REG_W-1:0] load_vreg;
  logic [`VLANE_IDX_W-1:0] load_index;
  logic [31:0]             load_data;
  logic [`VLANE_REG_W-1:0] rd_vreg;
  logic [`VLANE_IDX_W-1:0] rd_index;
  logic                    busy;
  logic                    done;
  logic [31:0]             rd_data;

  logic [31:0] shadow [`VLANE_NREGS][`VLANE_MAXVL];
  logic [31:0] lfsr = 32'd4;
  int          errors = 0;
  int          test_errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          cycle_count = 0;
  string       test_name;
  logic        check_req = 1'b0;
  int          check_vreg = 0;
  valu_op_t    sew_ops [8] = '{VALU_SLT, VALU_MIN, VALU_MAX, VALU_SLL,
                               VALU_SRL, VALU_SRA, VALU_EXT, VALU_EXT};
  valu_op_t    red_ops [8] = '{VALU_ADD, VALU_AND, VALU_OR, VALU_XOR,
                               VALU_MIN, VALU_MAX, VALU_MINU, VALU_MAXU};

  vector_lane_top dut_i (.*);

  always #10 CLK = ~CLK;

  // right-shift galois form of x^32 + x^31 + x^29 + x + 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'hD000_0001;
    end
    return s >> 1;
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic int sew_bits(sew_t s);
    return (s == SEW8) ? 8 : (s == SEW16) ? 16 : 32;
  endfunction

  // word whose upper bits disagree with the sew and half-sew sign bits
  function automatic logic [31:0] conflict_word(sew_t s);
    logic [31:0] w;
    int          n;
    w = rand_bits(32);
    n = sew_bits(s);
    if (n < 32) begin
      w[n-1] = ~w[31];
    end
    w[n/2-1] = ~w[31];
    return w;
  endfunction

  // expected element result for a as vs1 or the fold and b as vs2
  function automatic logic [31:0] ref_alu(valu_op_t op, sew_t s, ext_type_t et,
                                          logic [31:0] a, logic [31:0] b);
    int                 n;
    int                 sh;
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic signed [31:0] fld;
    logic signed [31:0] full;
    logic [31:0]        r;
    n  = sew_bits(s);
    sa = a << (32 - n);
    sa = sa >>> (32 - n);
    sb = b << (32 - n);
    sb = sb >>> (32 - n);
    sh = a & (n - 1);
    fld = b << (32 - n / 2);
    if (et == F2S) begin
      fld = fld >>> (32 - n / 2);
    end else begin
      fld = fld >> (32 - n / 2);
    end
    full = b;
    case (op)
      VALU_ADD:  r = b + a;
      VALU_SUB:  r = b - a;
      VALU_AND:  r = b & a;
      VALU_OR:   r = b | a;
      VALU_XOR:  r = b ^ a;
      VALU_SLL:  r = b << sh;
      VALU_SRL:  r = b >> sh;
      VALU_SRA:  r = full >>> sh;
      VALU_MIN:  r = (sb < sa) ? b : a;
      VALU_MAX:  r = (sb < sa) ? a : b;
      VALU_MINU: r = (b < a) ? b : a;
      VALU_MAXU: r = (b < a) ? a : b;
      VALU_SEQ:  r = (b == a) ? 32'd1 : 32'd0;
      VALU_SLT:  r = (sb < sa) ? 32'd1 : 32'd0;
      VALU_SLTU: r = (b < a) ? 32'd1 : 32'd0;
      default:   r = fld;
    endcase
    return r;
  endfunction

  task automatic compare_val(string name, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      $display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  task automatic load_elem(int v, int e, logic [31:0] data);
    @(posedge CLK);
    #2;
    load_en    = 1'b1;
    load_vreg  = v;
    load_index = e;
    load_data  = data;
    @(posedge CLK);
    #2;
    load_en = 1'b0;
    shadow[v][e] = data;
  endtask

  task automatic fill_reg(int v, logic conflict, sew_t s);
    for (int e = 0; e < `VLANE_MAXVL; e++) begin
      load_elem(v, e, conflict ? conflict_word(s) : rand_bits(32));
    end
  endtask

  // hands one register to the read-port checker and waits for it
  task automatic check_reg(int v);
    check_vreg = v;
    check_req  = 1'b1;
    wait (!check_req);
  endtask

  // disturb 1 pokes start into v3 and 2 pokes a load into v3[5]
  task automatic run_op(valu_op_t op, sew_t s, ext_type_t et, logic red,
                        int v1, int v2, int vdd, int n, int disturb);
    int          cyc;
    int          busy_cycles;
    int          done_at;
    logic [31:0] acc;
    if (red && n > 0) begin
      acc = ref_alu(op, s, et, shadow[v1][0], shadow[v2][0]);
      for (int i = 1; i < n; i++) begin
        acc = ref_alu(op, s, et, acc, shadow[v2][i]);
      end
      shadow[vdd][0] = acc;
    end else if (!red) begin
      for (int i = 0; i < n; i++) begin
        shadow[vdd][i] = ref_alu(op, s, et, shadow[v1][i], shadow[v2][i]);
      end
    end
    @(posedge CLK);
    #2;
    aluop     = op;
    sew       = s;
    ext_type  = et;
    reduction = red;
    vs1       = v1;
    vs2       = v2;
    vd        = vdd;
    vl        = n;
    start     = 1'b1;
    @(posedge CLK);
    #2;
    start = 1'b0;
    fork
      begin
        if (disturb != 0) begin
          @(posedge CLK);
          #2;
          if (disturb == 1) begin
            start = 1'b1;
            vd    = 3;
          end else begin
            load_en    = 1'b1;
            load_vreg  = 3;
            load_index = 5;
            load_data  = ~shadow[3][5];
          end
          @(posedge CLK);
          #2;
          start   = 1'b0;
          load_en = 1'b0;
        end
      end
      begin
        cyc         = 0;
        busy_cycles = 0;
        done_at     = 0;
        while (done_at == 0) begin
          @(negedge CLK);
          cyc++;
          if (busy) begin
            busy_cycles++;
          end
          if (done) begin
            done_at = cyc;
            compare_val("busy", 1'b0, busy);
          end
        end
        @(negedge CLK);
        compare_val("done", 1'b0, done);
        compare_val("busy_cycles", n, busy_cycles);
        compare_val("done_cycle", n + 1, done_at);
      end
    join
  endtask

  task automatic begin_test(string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
    end
    $display("test %0d %s: %s, %0d mismatches", tests_run, test_name,
             (test_errors == 0) ? "ok" : "FAILED", test_errors);
  endtask

  // read port checker comparing one whole register against the shadow
  always begin
    wait (check_req);
    for (int e = 0; e < `VLANE_MAXVL; e++) begin
      rd_vreg  = check_vreg;
      rd_index = e;
      #1;
      compare_val($sformatf("rd_data v%0d[%0d]", check_vreg, e),
                  shadow[check_vreg][e], rd_data);
    end
    check_req = 1'b0;
  end

  always @(posedge CLK) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, the lane never finished", cycle_count);
      $display("Testbench failed");
      $finish;
    end
  end

  initial begin
    CLK = 1'b0;
    nRST = 1'b0;
    start = 1'b0;
    aluop = VALU_ADD;
    sew = SEW32;
    ext_type = F2Z;
    reduction = 1'b0;
    vs1 = '0;
    vs2 = '0;
    vd = '0;
    vl = '0;
    load_en = 1'b0;
    load_vreg = '0;
    load_index = '0;
    load_data = '0;
    rd_vreg = '0;
    rd_index = '0;
    for (int r = 0; r < `VLANE_NREGS; r++) begin
      for (int e = 0; e < `VLANE_MAXVL; e++) begin
        shadow[r][e] = '0;
      end
    end
    repeat (RESET_CYCLES) @(posedge CLK);
    #2;
    nRST = 1'b1;

    begin_test("loads and reads");
    compare_val("busy", 1'b0, busy);
    compare_val("done", 1'b0, done);
    for (int r = 0; r < `VLANE_NREGS; r++) begin
      fill_reg(r, 1'b0, SEW32);
      check_reg(r);
    end
    // a reduction leaves the lane write port idle while v3[5] is poked
    run_op(VALU_ADD, SEW32, F2Z, 1'b1, 0, 1, 2, 8, 2);
    check_reg(2);
    check_reg(3);
    end_test();

    begin_test("element ops");
    for (int s = 0; s < 3; s++) begin
      fill_reg(0, 1'b0, sew_t'(s));
      fill_reg(1, 1'b0, sew_t'(s));
      for (int k = 0; k < 17; k++) begin
        run_op((k < 16) ? valu_op_t'(k) : VALU_EXT, sew_t'(s), (k < 16) ? F2Z : F2S,
               1'b0, 0, 1, 2, 8, 0);
        check_reg(2);
      end
    end
    // short vl leaves the tail of v3 alone
    run_op(VALU_XOR, SEW32, F2Z, 1'b0, 0, 1, 3, 5, 0);
    check_reg(3);
    end_test();

    begin_test("sew dependence");
    for (int s = 0; s < 3; s++) begin
      fill_reg(0, 1'b1, sew_t'(s));
      fill_reg(1, 1'b1, sew_t'(s));
      for (int k = 0; k < 8; k++) begin
        run_op(sew_ops[k], sew_t'(s), (k == 7) ? F2S : F2Z, 1'b0, 0, 1, 2, 8, 0);
        check_reg(2);
      end
    end
    end_test();

    begin_test("reductions");
    fill_reg(0, 1'b0, SEW32);
    fill_reg(1, 1'b0, SEW32);
    for (int k = 0; k < 8; k++) begin
      run_op(red_ops[k], sew_t'(k % 3), F2Z, 1'b1, 0, 1, 3, k + 1, 0);
      check_reg(3);
    end
    end_test();

    begin_test("busy and done timing");
    run_op(VALU_SUB, SEW32, F2Z, 1'b0, 0, 1, 2, 0, 0);
    check_reg(2);
    run_op(VALU_OR, SEW16, F2Z, 1'b0, 0, 1, 2, 3, 0);
    check_reg(2);
    run_op(VALU_AND, SEW8, F2Z, 1'b0, 0, 1, 2, 8, 1);
    check_reg(2);
    check_reg(3);
    end_test();

    $display("tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: filelist.f
+incdir+src
src/vlane_pkg.sv
src/vlane_if.sv
src/elem_counter.sv
src/lane_sequencer.sv
src/vreg_file.sv
src/arithmetic_unit.sv
src/vector_lane_top.sv
tests/vector_lane_tb.sv
